// File: fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// ******************************
// cache geometry
// ******************************

// byte offset bits within a line.
`define FETCH_OFFSET_BITS 4

// line index bits.
`define FETCH_INDEX_BITS 2

// address bits left above index and offset.
`define FETCH_TAG_BITS (32 - `FETCH_OFFSET_BITS - `FETCH_INDEX_BITS)

// ******************************
// fetch and bus constants
// ******************************

`define FETCH_RESET_PC 32'h8000_0000

// beats minus one per line, one word per beat.
`define FETCH_BURST_LEN ((1 << (`FETCH_OFFSET_BITS - 2)) - 1)

`endif

// File: fetch_pkg.sv
package fetch_pkg;

  // ******************************
  // controller state
  // ******************************

  typedef enum logic {
    state_lookup = 1'b0,  // hit path.
    state_refill = 1'b1   // line burst in flight.
  } fetch_state_t;

  // ******************************
  // internal links
  // ******************************

  typedef struct packed {
    logic [31:0] addr;  // pc, or miss line while refilling.
  } fetch_req_t;

  typedef struct packed {
    logic        hit;
    logic [31:0] word;
  } fetch_hit_t;

  typedef struct packed {
    logic        valid;  // accepted beat.
    logic        last;
    logic [31:0] data;
  } refill_beat_t;

  // ******************************
  // decode port
  // ******************************

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        misaligned;
  } fetch_out_t;

endpackage

// File: icache_array.sv
`include "fetch_params.svh"

module icache_array (
  input  logic                   clock,
  input  logic                   reset,
  input  fetch_pkg::fetch_req_t   req,
  input  logic                   invalidate,
  input  fetch_pkg::refill_beat_t beat,
  output fetch_pkg::fetch_hit_t   hit
);

  localparam int lines      = 1 << `FETCH_INDEX_BITS;
  localparam int line_words = `FETCH_BURST_LEN + 1;
  localparam int line_bits  = 32 * line_words;
  localparam int tag_lsb    = `FETCH_OFFSET_BITS + `FETCH_INDEX_BITS;

  logic [line_bits-1:0]       data_q [lines];
  logic [`FETCH_TAG_BITS-1:0] tag_q  [lines];
  logic [lines-1:0]           valid_q;

  logic [`FETCH_INDEX_BITS-1:0]  index;
  logic [`FETCH_TAG_BITS-1:0]    tag;
  logic [`FETCH_OFFSET_BITS-3:0] word_sel;
  logic [line_bits-1:0]          line;

  // ******************************
  // address split
  // ******************************

  assign index    = req.addr[tag_lsb-1:`FETCH_OFFSET_BITS];
  assign tag      = req.addr[31:tag_lsb];
  assign word_sel = req.addr[`FETCH_OFFSET_BITS-1:2];
  assign line     = data_q[index];

  // ******************************
  // lookup
  // ******************************

  always_comb begin
    hit.hit  = valid_q[index] && (tag_q[index] == tag);
    hit.word = line[int'(word_sel) * 32 +: 32];  // bits 3:2 pick the word.
  end

  // ******************************
  // valid bits
  // ******************************

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      if (invalidate) begin
        valid_q <= '0;
      end
      if (beat.valid) begin
        valid_q[index] <= 1'b1;  // refill beat wins over invalidate.
      end
    end
  end

  // ******************************
  // line and tag storage
  // ******************************

  always_ff @(posedge clock) begin
    if (beat.valid) begin
      // words enter at the top and move down, word 0 ends at bit 0.
      data_q[index] <= {beat.data, line[line_bits-1:32]};
      tag_q[index]  <= tag;
    end
  end

endmodule

// File: refill_master.sv
`include "fetch_params.svh"

module refill_master (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start,
  input  logic [31:0]            addr,
  output logic [31:0]            araddr,
  output logic [7:0]             arlen,
  output logic                   arvalid,
  input  logic                   arready,
  input  logic [31:0]            rdata,
  input  logic [1:0]             rresp,
  input  logic                   rvalid,
  input  logic                   rlast,
  output logic                   rready,
  output fetch_pkg::refill_beat_t beat
);

  logic idle;
  logic ar_done;
  logic r_take;

  assign idle    = !arvalid && !rready;
  assign ar_done = arvalid && arready;
  assign r_take  = rready && rvalid;

  // ******************************
  // address channel
  // ******************************

  always_ff @(posedge clock) begin
    if (reset) begin
      arvalid <= 1'b0;
    end else if (start && idle) begin
      arvalid <= 1'b1;
    end else if (ar_done) begin
      arvalid <= 1'b0;  // held until accepted.
    end
  end

  always_ff @(posedge clock) begin
    if (start && idle) begin
      araddr <= addr;
      arlen  <= 8'(`FETCH_BURST_LEN);
    end
  end

  // ******************************
  // read data channel
  // ******************************

  always_ff @(posedge clock) begin
    if (reset) begin
      rready <= 1'b0;
    end else if (ar_done) begin
      rready <= 1'b1;
    end else if (r_take && rlast) begin
      rready <= 1'b0;  // burst done.
    end
  end

  // each accepted beat goes straight to cache and control.
  always_comb begin
    beat.valid = r_take;
    beat.last  = rlast;
    beat.data  = rdata;
  end

endmodule

// File: fetch_ctrl.sv
`include "fetch_params.svh"

module fetch_ctrl (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [31:0]            npc,
  input  logic                   clear_pipeline,
  input  logic                   stall,
  input  logic                   clear_cache,
  input  logic                   ready,
  input  fetch_pkg::fetch_hit_t   hit,
  input  fetch_pkg::refill_beat_t beat,
  output fetch_pkg::fetch_req_t   req,
  output logic                   invalidate,
  output logic                   refill_start,
  output logic [31:0]            refill_addr,
  output fetch_pkg::fetch_out_t   out,
  output logic                   busy
);

  fetch_pkg::fetch_state_t state_q;
  fetch_pkg::fetch_state_t state_d;

  logic [31:0] pc_q;
  logic [31:0] miss_line_q;
  logic        valid_q;
  logic        misaligned_q;
  logic [31:0] out_pc_q;
  logic [31:0] out_inst_q;

  logic advance;
  logic aligned;
  logic lookup;

  // ******************************
  // lookup decisions
  // ******************************

  assign advance = ready && !stall;
  assign aligned = (pc_q[1:0] == 2'b00);
  // redirect beats any lookup in the same cycle.
  assign lookup  = (state_q == fetch_pkg::state_lookup) && advance && !clear_pipeline;

  assign refill_start = lookup && aligned && !hit.hit;
  assign refill_addr  = {pc_q[31:`FETCH_OFFSET_BITS], {`FETCH_OFFSET_BITS{1'b0}}};

  assign invalidate = clear_cache;
  assign busy       = (state_q == fetch_pkg::state_refill);

  // cache sees the miss line for the whole burst.
  assign req.addr = busy ? miss_line_q : pc_q;

  // ******************************
  // state machine
  // ******************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::state_lookup: begin
        if (refill_start) begin
          state_d = fetch_pkg::state_refill;
        end
      end
      fetch_pkg::state_refill: begin
        if (beat.valid && beat.last) begin
          state_d = fetch_pkg::state_lookup;
        end
      end
      default: state_d = fetch_pkg::state_lookup;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= fetch_pkg::state_lookup;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clock) begin
    if (refill_start) begin
      miss_line_q <= refill_addr;
    end
  end

  // ******************************
  // pc and output valid
  // ******************************

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q         <= `FETCH_RESET_PC;
      valid_q      <= 1'b0;
      misaligned_q <= 1'b0;
    end else if (clear_pipeline) begin
      pc_q         <= npc;
      valid_q      <= 1'b0;
      misaligned_q <= 1'b0;
    end else if (lookup) begin
      if (!aligned) begin
        valid_q      <= 1'b1;  // pc stays put until redirect.
        misaligned_q <= 1'b1;
      end else if (hit.hit) begin
        pc_q         <= pc_q + 32'd4;
        valid_q      <= 1'b1;
        misaligned_q <= 1'b0;
      end else begin
        valid_q      <= 1'b0;  // miss.
        misaligned_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (lookup && (hit.hit || !aligned)) begin
      out_pc_q   <= pc_q;
      out_inst_q <= hit.word;
    end
  end

  // ******************************
  // decode port
  // ******************************

  // a stalled cycle must not count as a transfer.
  always_comb begin
    out.valid      = valid_q && !stall;
    out.pc         = out_pc_q;
    out.inst       = out_inst_q;
    out.misaligned = misaligned_q;
  end

endmodule

// File: fetch_top.sv
module fetch_top (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [31:0]          npc,
  input  logic                 clear_pipeline,
  input  logic                 stall,
  input  logic                 clear_cache,
  input  logic                 ready,
  output fetch_pkg::fetch_out_t out,
  output logic                 busy,
  output logic [31:0]          araddr,
  output logic [7:0]           arlen,
  output logic                 arvalid,
  input  logic                 arready,
  input  logic [31:0]          rdata,
  input  logic [1:0]           rresp,
  input  logic                 rvalid,
  input  logic                 rlast,
  output logic                 rready
);

  fetch_pkg::fetch_req_t   req;
  fetch_pkg::fetch_hit_t   hit;
  fetch_pkg::refill_beat_t beat;

  logic        invalidate;
  logic        refill_start;
  logic [31:0] refill_addr;

  // ******************************
  // control
  // ******************************

  fetch_ctrl u_ctrl (
    .clock          (clock),
    .reset          (reset),
    .npc            (npc),
    .clear_pipeline (clear_pipeline),
    .stall          (stall),
    .clear_cache    (clear_cache),
    .ready          (ready),
    .hit            (hit),
    .beat           (beat),
    .req            (req),
    .invalidate     (invalidate),
    .refill_start   (refill_start),
    .refill_addr    (refill_addr),
    .out            (out),
    .busy           (busy)
  );

  // ******************************
  // storage and bus master
  // ******************************

  icache_array u_cache (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .invalidate (invalidate),
    .beat       (beat),
    .hit        (hit)
  );

  refill_master u_refill (
    .clock   (clock),
    .reset   (reset),
    .start   (refill_start),
    .addr    (refill_addr),
    .araddr  (araddr),
    .arlen   (arlen),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rlast   (rlast),
    .rready  (rready),
    .beat    (beat)
  );

endmodule

// File: tb_mem_model.sv
module tb_mem_model (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] araddr,
  input  logic [7:0]  arlen,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  output logic        rlast,
  input  logic        rready
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] data_key = 32'h5a5a_0000;

  integer seed = 32'h9a0d_0bae;

  logic        ar_hs;
  logic        r_hs;
  logic        active;
  logic [31:0] base_addr;
  logic [7:0]  burst_len;
  logic [7:0]  beat_index;

  // ******************************
  // handshakes seen at the edge
  // ******************************

  always @(posedge clock) begin
    ar_hs <= arvalid && arready;
    r_hs  <= rvalid && rready;
    if (arvalid && arready) begin
      base_addr <= araddr;
      burst_len <= arlen;
    end
  end

  // ******************************
  // slave outputs, falling edge
  // ******************************

  always @(negedge clock) begin
    if (reset) begin
      arready    <= 1'b0;
      rvalid     = 1'b0;
      rlast      <= 1'b0;
      rdata      <= '0;
      rresp      <= 2'b00;
      active     = 1'b0;
      beat_index = '0;
    end else begin
      if (ar_hs) begin
        active     = 1'b1;
        beat_index = '0;
      end
      if (r_hs) begin
        rvalid = 1'b0;
        if (rlast) begin
          active = 1'b0;
        end
        beat_index = beat_index + 8'd1;
      end
      arready <= !active && arvalid && !ar_hs && (($random(seed) & 3) != 0);
      if (active && !rvalid && (($random(seed) & 3) != 0)) begin
        rvalid = 1'b1;
        rdata  <= (base_addr + {22'd0, beat_index, 2'b00}) ^ data_key;  // line word.
        rlast  <= (beat_index == burst_len);
      end
      rresp <= 2'b00;
    end
  end

endmodule

// File: tb_fetch.sv
`include "fetch_params.svh"

module tb_fetch;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] data_key = 32'h5a5a_0000;

  logic                  clock = 1'b0;
  logic                  reset = 1'b1;
  logic [31:0]           npc;
  logic                  clear_pipeline;
  logic                  stall;
  logic                  clear_cache;
  logic                  ready;
  fetch_pkg::fetch_out_t out;
  logic                  busy;
  logic [31:0]           araddr;
  logic [7:0]            arlen;
  logic                  arvalid;
  logic                  arready;
  logic [31:0]           rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rlast;
  logic                  rready;

  integer      seed = 32'h9a0d_0bae;
  int          errors;
  int          checks;
  int          bursts;
  int          burst_mark;
  int          cycles;
  int          cycle_limit;
  logic [31:0] exp_pc;
  string       cur_test;

  fetch_top dut0 (
    .clock (clock), .reset (reset), .npc (npc), .clear_pipeline (clear_pipeline),
    .stall (stall), .clear_cache (clear_cache), .ready (ready), .out (out), .busy (busy),
    .araddr (araddr), .arlen (arlen), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rlast (rlast), .rready (rready)
  );

  tb_mem_model mem0 (
    .clock (clock), .reset (reset), .araddr (araddr), .arlen (arlen),
    .arvalid (arvalid), .arready (arready), .rdata (rdata), .rresp (rresp),
    .rvalid (rvalid), .rlast (rlast), .rready (rready)
  );

  always #20 clock = ~clock;

  // ******************************
  // burst count and watchdog
  // ******************************

  always @(posedge clock) begin
    if (!reset && arvalid && arready) begin
      bursts <= bursts + 1;
      compare(cur_test, 32'd1, {31'd0, busy});  // refill state while the burst runs.
      compare(cur_test, 32'd3, {24'd0, arlen});  // four beats per line.
      compare(cur_test, exp_pc & 32'hffff_fff0, araddr);  // line of the next pc.
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ******************************
  // drive and check helpers
  // ******************************

  // took is high when the next rising edge transfers an instruction.
  task automatic drive_cycle(input logic rdy, input logic stl, output logic took);
    @(negedge clock);
    ready          = rdy;
    stall          = stl;
    clear_pipeline = 1'b0;
    clear_cache    = 1'b0;
    #1;
    took = out.valid && ready;
  endtask

  task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] act);
    checks++;
    assert (expv === act) else begin
      $display("ERR %s expected %h actual %h", name, expv, act);
      errors++;
    end
  endtask

  task automatic check_transfer(input string name);
    if (exp_pc[1:0] != 2'b00) begin
      compare(name, 32'd1, {31'd0, out.misaligned});
      compare(name, exp_pc, out.pc);  // held until a redirect.
    end else begin
      compare(name, 32'd0, {31'd0, out.misaligned});
      compare(name, exp_pc, out.pc);
      compare(name, exp_pc ^ data_key, out.inst);
      exp_pc = exp_pc + 32'd4;
    end
  endtask

  task automatic run_fetch(input string name, input int count, input int gaps);
    int   taken;
    logic rdy;
    logic stl;
    logic took;
    taken = 0;
    while (taken < count) begin
      rdy = 1'b1;
      stl = 1'b0;
      if (gaps != 0) begin
        rdy = ($random(seed) & 3) != 0;
        stl = ($random(seed) & 7) == 0;
      end
      drive_cycle(rdy, stl, took);
      if (took) begin
        check_transfer(name);
        taken++;
      end
    end
  endtask

  task automatic run_stall(input string name, input int count);
    logic took;
    repeat (count) begin
      drive_cycle(1'b1, 1'b1, took);
      checks++;
      assert (!took) else begin
        $display("%s: an instruction was taken while stalled", name);
        errors++;
      end
    end
  endtask

  task automatic pulse_control(input logic redirect, input logic flush, input logic [31:0] addr);
    logic took;
    @(negedge clock);
    ready          = 1'b0;
    stall          = 1'b0;
    npc            = addr;
    clear_pipeline = redirect;
    clear_cache    = flush;
    drive_cycle(1'b0, 1'b0, took);
  endtask

  task automatic check_bursts(input string name, input int expected);
    logic took;
    drive_cycle(1'b0, 1'b0, took);
    while (busy) begin
      drive_cycle(1'b0, 1'b0, took);
    end
    compare(name, expected, bursts - burst_mark);
    burst_mark = bursts;
  endtask

  // ******************************
  // main sequence
  // ******************************

  initial begin
    int          fd;
    int          code;
    int          total;
    int          n;
    int          g;
    string       cmd;
    string       name;
    string       line;
    logic [31:0] value;

    npc            = '0;
    clear_pipeline = 1'b0;
    stall          = 1'b0;
    clear_cache    = 1'b0;
    ready          = 1'b0;
    errors         = 0;
    checks         = 0;
    bursts         = 0;
    burst_mark     = 0;
    cycles         = 0;
    cycle_limit    = 0;
    exp_pc         = `FETCH_RESET_PC;
    cur_test       = "reset";
    total          = 0;

    // first pass sizes the watchdog.
    fd = $fopen("fetch_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open fetch_cases.txt");
      $display("Simulation FAILED");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        n    = 0;
        code = $sscanf(line, "%s %s %d", cmd, name, n);
        if (code == 3 && cmd == "fetch") begin
          total += n;
        end
      end
      $fclose(fd);
      cycle_limit = 200 * total + 1000;

      repeat (3) @(negedge clock);
      reset = 1'b0;

      fd = $fopen("fetch_cases.txt", "r");
      while ($fscanf(fd, "%s", cmd) == 1) begin
        if (cmd.substr(0, 0) == "#") begin
          code = $fgets(line, fd);
        end else if (cmd == "redirect") begin
          code     = $fscanf(fd, "%s %h", name, value);
          cur_test = name;
          exp_pc   = value;
          pulse_control(1'b1, 1'b0, value);
        end else if (cmd == "fetch") begin
          code     = $fscanf(fd, "%s %d %d", name, n, g);
          cur_test = name;
          run_fetch(name, n, g);
        end else if (cmd == "stall") begin
          code     = $fscanf(fd, "%s %d", name, n);
          cur_test = name;
          run_stall(name, n);
        end else if (cmd == "flush") begin
          code     = $fscanf(fd, "%s", name);
          cur_test = name;
          pulse_control(1'b0, 1'b1, npc);
        end else if (cmd == "expect_bursts") begin
          code     = $fscanf(fd, "%s %d", name, n);
          cur_test = name;
          check_bursts(name, n);
        end else begin
          $display("unknown command %s in the cases file", cmd);
          errors++;
        end
      end
      $fclose(fd);

      $display("checks %0d, errors %0d, bursts %0d", checks, errors, bursts);
      if (errors == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

endmodule

// File: fetch_cases.txt
# command test_name args: redirect addr(hex) | fetch count gaps | stall cycles
# flush | expect_bursts count (bursts since the last check)
fetch seq_fetch 15 0
expect_bursts seq_fetch 4
redirect hit_fetch 80000010
fetch hit_fetch 10 0
expect_bursts hit_fetch 0
redirect backpressure 80000000
fetch backpressure 12 1
stall backpressure 5
fetch backpressure 3 1
expect_bursts backpressure 0
flush flush_refetch
redirect flush_refetch 80000000
fetch flush_refetch 7 1
expect_bursts flush_refetch 2
redirect misaligned 80000022
fetch misaligned 1 0
expect_bursts misaligned 0
redirect resume_aligned 80000000
fetch resume_aligned 3 0
expect_bursts resume_aligned 0
redirect conflict_a 80000040
fetch conflict_a 2 0
expect_bursts conflict_a 1
redirect conflict_b 80000000
fetch conflict_b 2 1
expect_bursts conflict_b 1
redirect conflict_c 80000040
fetch conflict_c 2 0
expect_bursts conflict_c 1

// File: build.f
+incdir+.
fetch_pkg.sv
icache_array.sv
refill_master.sv
fetch_ctrl.sv
fetch_top.sv
tb_mem_model.sv
tb_fetch.sv

// File: Bender.yml
package:
  name: fetch

export_include_dirs:
  - .

sources:
  - fetch_pkg.sv
  - icache_array.sv
  - refill_master.sv
  - fetch_ctrl.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_fetch.sv
